/* hdl/isa_pkg.sv */
package isa_pkg;

  // Instruction register contents
  typedef logic [7:0] opcode_t;

  // Loads and stores
  localparam opcode_t OPC_LDA_IMM = 8'hA9;
  localparam opcode_t OPC_LDA_ZPG = 8'hA5;
  localparam opcode_t OPC_LDA_ABS = 8'hAD;
  localparam opcode_t OPC_LDX_IMM = 8'hA2;
  localparam opcode_t OPC_LDX_ZPG = 8'hA6;
  localparam opcode_t OPC_LDY_IMM = 8'hA0;
  localparam opcode_t OPC_LDY_ZPG = 8'hA4;
  localparam opcode_t OPC_STA_ZPG = 8'h85;
  localparam opcode_t OPC_STA_ABS = 8'h8D;
  localparam opcode_t OPC_STX_ZPG = 8'h86;
  localparam opcode_t OPC_STY_ZPG = 8'h84;

  // Register transfers
  localparam opcode_t OPC_TAX = 8'hAA;
  localparam opcode_t OPC_TAY = 8'hA8;
  localparam opcode_t OPC_TXA = 8'h8A;
  localparam opcode_t OPC_TYA = 8'h98;
  localparam opcode_t OPC_TSX = 8'hBA;
  localparam opcode_t OPC_TXS = 8'h9A;

  // Accumulator ALU ops
  localparam opcode_t OPC_ADC_IMM = 8'h69;
  localparam opcode_t OPC_ADC_ZPG = 8'h65;
  localparam opcode_t OPC_ADC_ABS = 8'h6D;
  localparam opcode_t OPC_AND_IMM = 8'h29;
  localparam opcode_t OPC_ORA_IMM = 8'h09;
  localparam opcode_t OPC_EOR_IMM = 8'h49;
  localparam opcode_t OPC_CMP_IMM = 8'hC9;
  localparam opcode_t OPC_CMP_ZPG = 8'hC5;

  // Index register steps
  localparam opcode_t OPC_INX = 8'hE8;
  localparam opcode_t OPC_INY = 8'hC8;
  localparam opcode_t OPC_DEX = 8'hCA;
  localparam opcode_t OPC_DEY = 8'h88;

  // Shifts, rotates and memory increments
  localparam opcode_t OPC_ASL_ACC = 8'h0A;
  localparam opcode_t OPC_ASL_ZPG = 8'h06;
  localparam opcode_t OPC_ASL_ABS = 8'h0E;
  localparam opcode_t OPC_LSR_ACC = 8'h4A;
  localparam opcode_t OPC_ROL_ACC = 8'h2A;
  localparam opcode_t OPC_ROR_ACC = 8'h6A;
  localparam opcode_t OPC_INC_ZPG = 8'hE6;
  localparam opcode_t OPC_INC_ABS = 8'hEE;
  localparam opcode_t OPC_DEC_ZPG = 8'hC6;

  // Flags, jumps and the rest
  localparam opcode_t OPC_CLC = 8'h18;
  localparam opcode_t OPC_SEC = 8'h38;
  localparam opcode_t OPC_JMP_ABS = 8'h4C;
  localparam opcode_t OPC_JSR_ABS = 8'h20;
  localparam opcode_t OPC_RTS = 8'h60;
  localparam opcode_t OPC_NOP = 8'hEA;

  // Carry bit of the status register
  localparam logic [7:0] FLAG_MASK_C = 8'h01;

  typedef enum logic [5:0] {
    OP_NOP, OP_LDA, OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY,
    OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS,
    OP_ADC, OP_AND, OP_ORA, OP_EOR, OP_CMP,
    OP_INX, OP_INY, OP_DEX, OP_DEY,
    OP_ASL, OP_LSR, OP_ROL, OP_ROR, OP_INC, OP_DEC,
    OP_CLC, OP_SEC, OP_JMP, OP_JSR, OP_RTS
  } op_e;

  typedef enum logic [2:0] {AM_IMP, AM_ACC, AM_IMM, AM_ZPG, AM_ABS} addr_mode_e;

  typedef enum logic [2:0] {
    CL_LOAD, CL_STORE, CL_XFER, CL_ALU, CL_RMW, CL_FLAG, CL_JUMP, CL_NONE
  } op_class_e;

  typedef struct packed {
    op_e        op;
    addr_mode_e mode;
    op_class_e  cls;
  } decoded_t;

endpackage

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

  // Machine cycles of the sequencer
  typedef enum logic [2:0] {
    ST_FETCH, ST_OPERAND, ST_ADDR_HI, ST_READ, ST_MODIFY, ST_WRITE, ST_STACK
  } state_e;

  localparam int STEP_W = 2;
  typedef logic [STEP_W-1:0] step_t;

  // Control fields, zero value is the idle choice except for rw
  typedef enum logic {RW_W = 1'b0, RW_R = 1'b1} rw_e;
  typedef enum logic [2:0] {DB_A, DB_X, DB_Y, DB_T, DB_PCL, DB_PCH, DB_P} db_src_e;
  typedef enum logic [2:0] {REG_MEM, REG_ALU, REG_T, REG_A, REG_X, REG_Y, REG_S} reg_src_e;
  typedef enum logic [3:0] {
    ALU_THA, ALU_ADC, ALU_AND, ALU_ORA, ALU_EOR, ALU_CMP,
    ALU_INC, ALU_DEC, ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR
  } alu_op_e;
  typedef enum logic [2:0] {ALUA_A, ALUA_X, ALUA_Y, ALUA_S, ALUA_T} alu_src_a_e;
  typedef enum logic [1:0] {P_NON, P_ALU, P_SET, P_CLR} p_src_e;
  typedef enum logic {PC_NOP, PC_INC} pc_add_e;
  typedef enum logic [1:0] {PCL_ADD, PCL_MEM, PCL_T} pcl_src_e;
  typedef enum logic {PCH_ADD, PCH_MEM} pch_src_e;
  typedef enum logic [2:0] {ABL_PCN, ABL_PCC, ABL_MEM, ABL_T, ABL_ALU, ABL_S} abl_src_e;
  typedef enum logic [2:0] {ABH_PCN, ABH_PCC, ABH_MEM, ABH_H00, ABH_H01} abh_src_e;

  typedef struct packed {
    rw_e     rw;
    db_src_e db_src;
    logic    ir_we;
  } bus_ctrl_t;

  typedef struct packed {
    reg_src_e reg_src;
    logic     a_we;
    logic     x_we;
    logic     y_we;
    logic     s_we;
    logic     t_we;
  } reg_ctrl_t;

  typedef struct packed {
    alu_op_e    op;
    alu_src_a_e src_a;
    p_src_e     p_src;
    logic [7:0] p_mask;
  } alu_ctrl_t;

  typedef struct packed {
    pc_add_e  pc_add;
    pcl_src_e pcl_src;
    pch_src_e pch_src;
    logic     pcl_we;
    logic     pch_we;
  } pc_ctrl_t;

  typedef struct packed {
    abl_src_e abl_src;
    abh_src_e abh_src;
    logic     abl_we;
    logic     abh_we;
  } ab_ctrl_t;

  typedef struct packed {
    bus_ctrl_t bus;
    reg_ctrl_t regs;
    alu_ctrl_t alu;
    pc_ctrl_t  pc;
    ab_ctrl_t  ab;
  } ctrl_word_t;

endpackage

/* hdl/instr_decoder.sv */
module instr_decoder (
  input  isa_pkg::opcode_t  instr,
  output isa_pkg::decoded_t dec
);

  import isa_pkg::*;

  always_comb begin
    case (instr)
      OPC_LDA_IMM: dec = '{OP_LDA, AM_IMM, CL_LOAD};
      OPC_LDA_ZPG: dec = '{OP_LDA, AM_ZPG, CL_LOAD};
      OPC_LDA_ABS: dec = '{OP_LDA, AM_ABS, CL_LOAD};
      OPC_LDX_IMM: dec = '{OP_LDX, AM_IMM, CL_LOAD};
      OPC_LDX_ZPG: dec = '{OP_LDX, AM_ZPG, CL_LOAD};
      OPC_LDY_IMM: dec = '{OP_LDY, AM_IMM, CL_LOAD};
      OPC_LDY_ZPG: dec = '{OP_LDY, AM_ZPG, CL_LOAD};
      OPC_STA_ZPG: dec = '{OP_STA, AM_ZPG, CL_STORE};
      OPC_STA_ABS: dec = '{OP_STA, AM_ABS, CL_STORE};
      OPC_STX_ZPG: dec = '{OP_STX, AM_ZPG, CL_STORE};
      OPC_STY_ZPG: dec = '{OP_STY, AM_ZPG, CL_STORE};
      OPC_TAX:     dec = '{OP_TAX, AM_IMP, CL_XFER};
      OPC_TAY:     dec = '{OP_TAY, AM_IMP, CL_XFER};
      OPC_TXA:     dec = '{OP_TXA, AM_IMP, CL_XFER};
      OPC_TYA:     dec = '{OP_TYA, AM_IMP, CL_XFER};
      OPC_TSX:     dec = '{OP_TSX, AM_IMP, CL_XFER};
      OPC_TXS:     dec = '{OP_TXS, AM_IMP, CL_XFER};
      OPC_ADC_IMM: dec = '{OP_ADC, AM_IMM, CL_ALU};
      OPC_ADC_ZPG: dec = '{OP_ADC, AM_ZPG, CL_ALU};
      OPC_ADC_ABS: dec = '{OP_ADC, AM_ABS, CL_ALU};
      OPC_AND_IMM: dec = '{OP_AND, AM_IMM, CL_ALU};
      OPC_ORA_IMM: dec = '{OP_ORA, AM_IMM, CL_ALU};
      OPC_EOR_IMM: dec = '{OP_EOR, AM_IMM, CL_ALU};
      OPC_CMP_IMM: dec = '{OP_CMP, AM_IMM, CL_ALU};
      OPC_CMP_ZPG: dec = '{OP_CMP, AM_ZPG, CL_ALU};
      OPC_INX:     dec = '{OP_INX, AM_IMP, CL_ALU};
      OPC_INY:     dec = '{OP_INY, AM_IMP, CL_ALU};
      OPC_DEX:     dec = '{OP_DEX, AM_IMP, CL_ALU};
      OPC_DEY:     dec = '{OP_DEY, AM_IMP, CL_ALU};
      // Accumulator shifts finish at the fetch, memory ones modify in place
      OPC_ASL_ACC: dec = '{OP_ASL, AM_ACC, CL_ALU};
      OPC_ASL_ZPG: dec = '{OP_ASL, AM_ZPG, CL_RMW};
      OPC_ASL_ABS: dec = '{OP_ASL, AM_ABS, CL_RMW};
      OPC_LSR_ACC: dec = '{OP_LSR, AM_ACC, CL_ALU};
      OPC_ROL_ACC: dec = '{OP_ROL, AM_ACC, CL_ALU};
      OPC_ROR_ACC: dec = '{OP_ROR, AM_ACC, CL_ALU};
      OPC_INC_ZPG: dec = '{OP_INC, AM_ZPG, CL_RMW};
      OPC_INC_ABS: dec = '{OP_INC, AM_ABS, CL_RMW};
      OPC_DEC_ZPG: dec = '{OP_DEC, AM_ZPG, CL_RMW};
      OPC_CLC:     dec = '{OP_CLC, AM_IMP, CL_FLAG};
      OPC_SEC:     dec = '{OP_SEC, AM_IMP, CL_FLAG};
      OPC_JMP_ABS: dec = '{OP_JMP, AM_ABS, CL_JUMP};
      OPC_JSR_ABS: dec = '{OP_JSR, AM_ABS, CL_JUMP};
      OPC_RTS:     dec = '{OP_RTS, AM_IMP, CL_JUMP};
      OPC_NOP:     dec = '{OP_NOP, AM_IMP, CL_NONE};
      // Unknown opcodes behave as a two cycle NOP
      default:     dec = '{OP_NOP, AM_IMP, CL_NONE};
    endcase
  end

endmodule

/* hdl/stack_step_counter.sv */
module stack_step_counter (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              rdy,
  input  logic              start,
  input  isa_pkg::decoded_t dec,
  output ctrl_pkg::step_t   step,
  output logic              last
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  logic  run;
  step_t last_step;

  // RTS needs one more step than JSR for the final PC increment
  assign last_step = (dec.op == OP_RTS) ? step_t'(3) : step_t'(2);
  assign last = run && (step == last_step);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
      step <= '0;
    end else if (rdy) begin
      if (start) begin
        run <= 1'b1;
        step <= '0;
      end else if (last) begin
        run <= 1'b0;
        step <= '0;
      end else if (run) begin
        step <= step + 1'b1;
      end
    end
  end

  a_step_range: assert property (@(posedge CLK) disable iff (!arst_n)
    run |-> step <= last_step);

endmodule

/* hdl/cycle_sequencer.sv */
module cycle_sequencer (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              rdy,
  input  isa_pkg::decoded_t dec,
  input  logic              stack_last,
  output ctrl_pkg::state_e  state,
  output logic              ending,
  output logic              stack_start
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  state_e state_nxt;

  always_comb begin
    state_nxt = ST_FETCH;
    case (state)
      ST_FETCH: state_nxt = ST_OPERAND;
      ST_OPERAND: begin
        if (dec.op == OP_RTS) begin
          state_nxt = ST_STACK;
        end else if (dec.mode == AM_ZPG) begin
          state_nxt = (dec.cls == CL_STORE) ? ST_WRITE : ST_READ;
        end else if (dec.mode == AM_ABS) begin
          state_nxt = ST_ADDR_HI;
        end
      end
      ST_ADDR_HI: begin
        if (dec.op == OP_JSR) begin
          state_nxt = ST_STACK;
        end else if (dec.op != OP_JMP) begin
          state_nxt = (dec.cls == CL_STORE) ? ST_WRITE : ST_READ;
        end
      end
      ST_READ: begin
        if (dec.cls == CL_RMW) begin
          state_nxt = ST_MODIFY;
        end
      end
      ST_MODIFY: state_nxt = ST_WRITE;
      // Counter decides how long the stack sequence runs
      ST_STACK: state_nxt = stack_last ? ST_FETCH : ST_STACK;
      default: state_nxt = ST_FETCH;
    endcase
  end

  assign ending = (state_nxt == ST_FETCH);
  assign stack_start = (state != ST_STACK) && (state_nxt == ST_STACK);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_FETCH;
    end else if (rdy) begin
      state <= state_nxt;
    end
  end

  a_stack_exit: assert property (@(posedge CLK) disable iff (!arst_n)
    (state == ST_STACK && rdy && !stack_last) |=> state == ST_STACK);

endmodule

/* hdl/control_encoder.sv */
module control_encoder (
  input  ctrl_pkg::state_e     state,
  input  ctrl_pkg::step_t      step,
  input  logic                 ending,
  input  isa_pkg::decoded_t    dec,
  output ctrl_pkg::ctrl_word_t ctrl
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  alu_op_e    exe_op;
  alu_src_a_e exe_src;
  reg_ctrl_t  move;
  logic       no_operand;

  // Implied and accumulator forms have no operand byte
  assign no_operand = (dec.mode == AM_IMP) || (dec.mode == AM_ACC);

  // ALU work of the instruction
  always_comb begin
    case (dec.op)
      OP_ADC: exe_op = ALU_ADC;
      OP_AND: exe_op = ALU_AND;
      OP_ORA: exe_op = ALU_ORA;
      OP_EOR: exe_op = ALU_EOR;
      OP_CMP: exe_op = ALU_CMP;
      OP_INX, OP_INY, OP_INC: exe_op = ALU_INC;
      OP_DEX, OP_DEY, OP_DEC: exe_op = ALU_DEC;
      OP_ASL: exe_op = ALU_ASL;
      OP_LSR: exe_op = ALU_LSR;
      OP_ROL: exe_op = ALU_ROL;
      OP_ROR: exe_op = ALU_ROR;
      default: exe_op = ALU_THA;
    endcase
    if (dec.cls == CL_RMW) begin
      exe_src = ALUA_T;
    end else if (dec.op == OP_INX || dec.op == OP_DEX) begin
      exe_src = ALUA_X;
    end else if (dec.op == OP_INY || dec.op == OP_DEY) begin
      exe_src = ALUA_Y;
    end else begin
      exe_src = ALUA_A;
    end
  end

  // Move table: source, then A X Y S T enables
  always_comb begin
    case (dec.op)
      OP_LDA: move = '{REG_T, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_LDX: move = '{REG_T, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      OP_LDY: move = '{REG_T, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
      OP_TAX: move = '{REG_A, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      OP_TAY: move = '{REG_A, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
      OP_TXA: move = '{REG_X, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_TYA: move = '{REG_Y, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      OP_TSX: move = '{REG_S, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      OP_TXS: move = '{REG_X, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
      default: move = '{REG_MEM, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.bus.rw = RW_R;
    case (state)
      ST_FETCH: begin
        ctrl.bus.ir_we = 1'b1;
        // Write back of the instruction that just finished
        ctrl.regs = move;
        if (dec.cls == CL_ALU) begin
          ctrl.alu.op = exe_op;
          ctrl.alu.src_a = exe_src;
          ctrl.alu.p_src = P_ALU;
          ctrl.regs.reg_src = REG_ALU;
          ctrl.regs.a_we = (exe_src == ALUA_A) && (dec.op != OP_CMP);
          ctrl.regs.x_we = (exe_src == ALUA_X);
          ctrl.regs.y_we = (exe_src == ALUA_Y);
        end else if (dec.op == OP_SEC || dec.op == OP_CLC) begin
          ctrl.alu.p_src = (dec.op == OP_SEC) ? P_SET : P_CLR;
          ctrl.alu.p_mask = FLAG_MASK_C;
        end
        ctrl.pc = '{PC_INC, PCL_ADD, PCH_ADD, 1'b1, 1'b1};
        ctrl.ab.abl_we = 1'b1;
        ctrl.ab.abh_we = 1'b1;
      end
      ST_OPERAND: begin
        ctrl.regs.t_we = !no_operand;
        ctrl.pc = '{no_operand ? PC_NOP : PC_INC, PCL_ADD, PCH_ADD, 1'b1, 1'b1};
        if (dec.mode == AM_ZPG) begin
          ctrl.ab.abl_src = ABL_MEM;
          ctrl.ab.abh_src = ABH_H00;
        end else if (dec.op == OP_JSR || dec.op == OP_RTS) begin
          ctrl.ab.abl_src = ABL_S;
          ctrl.ab.abh_src = ABH_H01;
        end
        ctrl.ab.abl_we = 1'b1;
        ctrl.ab.abh_we = 1'b1;
      end
      ST_ADDR_HI: begin
        ctrl.pc.pc_add = (dec.op == OP_JSR) ? PC_NOP : PC_INC;
        if (dec.op == OP_JMP) begin
          ctrl.pc.pcl_src = PCL_T;
          ctrl.pc.pch_src = PCH_MEM;
        end
        ctrl.pc.pcl_we = 1'b1;
        ctrl.pc.pch_we = 1'b1;
        // JSR keeps the stack address from the operand cycle
        if (dec.op != OP_JSR) begin
          ctrl.ab = '{ABL_T, ABH_MEM, 1'b1, 1'b1};
        end
      end
      ST_READ: begin
        ctrl.regs.t_we = 1'b1;
        if (ending) begin
          ctrl.ab = '{ABL_PCC, ABH_PCC, 1'b1, 1'b1};
        end
      end
      ST_MODIFY: begin
        ctrl.bus.rw = RW_W;
        ctrl.alu.op = exe_op;
        ctrl.alu.src_a = exe_src;
        ctrl.alu.p_src = P_ALU;
        ctrl.regs.reg_src = REG_ALU;
        ctrl.regs.t_we = 1'b1;
      end
      ST_WRITE: begin
        ctrl.bus.rw = RW_W;
        case (dec.op)
          OP_STA: ctrl.bus.db_src = DB_A;
          OP_STX: ctrl.bus.db_src = DB_X;
          OP_STY: ctrl.bus.db_src = DB_Y;
          default: ctrl.bus.db_src = DB_T;
        endcase
        ctrl.ab = '{ABL_PCC, ABH_PCC, 1'b1, 1'b1};
      end
      ST_STACK: begin
        if (dec.op == OP_JSR) begin
          if (step != 2'd2) begin
            // Push PCH then PCL, S steps down each time
            ctrl.bus.rw = RW_W;
            ctrl.bus.db_src = (step == 2'd0) ? DB_PCH : DB_PCL;
            ctrl.alu.op = ALU_DEC;
            ctrl.alu.src_a = ALUA_S;
            ctrl.regs.reg_src = REG_ALU;
            ctrl.regs.s_we = 1'b1;
            if (step == 2'd0) begin
              ctrl.ab.abl_src = ABL_ALU;
              ctrl.ab.abl_we = 1'b1;
            end else begin
              ctrl.ab = '{ABL_PCC, ABH_PCC, 1'b1, 1'b1};
            end
          end else begin
            ctrl.pc = '{PC_NOP, PCL_T, PCH_MEM, 1'b1, 1'b1};
            ctrl.ab = '{ABL_T, ABH_MEM, 1'b1, 1'b1};
          end
        end else begin
          case (step)
            2'd0, 2'd1: begin
              ctrl.alu.op = ALU_INC;
              ctrl.alu.src_a = ALUA_S;
              ctrl.regs.reg_src = REG_ALU;
              ctrl.regs.s_we = 1'b1;
              ctrl.ab.abl_src = ABL_ALU;
              ctrl.ab.abl_we = 1'b1;
              // Return address low byte arrives on the second step
              ctrl.pc.pcl_src = PCL_MEM;
              ctrl.pc.pcl_we = (step == 2'd1);
            end
            2'd2: begin
              ctrl.pc.pch_src = PCH_MEM;
              ctrl.pc.pch_we = 1'b1;
              ctrl.ab.abl_we = 1'b1;
              ctrl.ab.abh_we = 1'b1;
            end
            default: begin
              ctrl.pc = '{PC_INC, PCL_ADD, PCH_ADD, 1'b1, 1'b1};
              ctrl.ab.abl_we = 1'b1;
              ctrl.ab.abh_we = 1'b1;
            end
          endcase
        end
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    a_fetch_no_write: assert (!(ctrl.bus.ir_we && ctrl.bus.rw == RW_W));
  end

endmodule

/* hdl/cpu_controller.sv */
module cpu_controller (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 rdy,
  input  isa_pkg::opcode_t     instr,
  output ctrl_pkg::ctrl_word_t ctrl
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  decoded_t dec;
  state_e   state;
  step_t    step;
  logic     ending;
  logic     stack_start;
  logic     stack_last;

  instr_decoder dec0 (
    .instr (instr),
    .dec   (dec)
  );

  cycle_sequencer seq0 (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .rdy         (rdy),
    .dec         (dec),
    .stack_last  (stack_last),
    .state       (state),
    .ending      (ending),
    .stack_start (stack_start)
  );

  // Step index for the JSR and RTS stack cycles
  stack_step_counter cnt0 (
    .CLK    (CLK),
    .arst_n (arst_n),
    .rdy    (rdy),
    .start  (stack_start),
    .dec    (dec),
    .step   (step),
    .last   (stack_last)
  );

  control_encoder enc0 (
    .state  (state),
    .step   (step),
    .ending (ending),
    .dec    (dec),
    .ctrl   (ctrl)
  );

endmodule

/* bench/cpu_controller_tb.sv */
module cpu_controller_tb;

  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam int NUM_INSTR = 40;
  localparam int STALL_INSTR = 12;
  // Six cycles per instruction at most plus up to three stalled cycles after each
  localparam int RUN_LIMIT = (NUM_INSTR * 6 + STALL_INSTR * 6 * 3 + 5) * 8 + 400;

  logic       CLK;
  logic       arst_n;
  logic       rdy;
  opcode_t    instr;
  ctrl_word_t ctrl;

  logic [31:0] rng_state;
  int          stall_left;
  logic        stall_on;
  ctrl_word_t  fetch_word;
  ctrl_word_t  wr_log[$];

  // One instruction per row of the timing table
  opcode_t len_opc [8] = '{OPC_TAX, OPC_LDA_ZPG, OPC_LDA_ABS, OPC_INC_ZPG,
                           OPC_ASL_ABS, OPC_JMP_ABS, OPC_JSR_ABS, OPC_RTS};
  int      len_exp [8] = '{2, 3, 4, 5, 6, 3, 6, 6};

  cpu_controller dut0 (
    .CLK    (CLK),
    .arst_n (arst_n),
    .rdy    (rdy),
    .instr  (instr),
    .ctrl   (ctrl)
  );

  always #4 CLK = ~CLK;

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bus(input string name, input bus_ctrl_t exp, input bus_ctrl_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_ctrl_t exp, input reg_ctrl_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_alu(input string name, input alu_ctrl_t exp, input alu_ctrl_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input pc_ctrl_t exp, input pc_ctrl_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ab(input string name, input ab_ctrl_t exp, input ab_ctrl_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_len(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic bus_ctrl_t make_bus(input rw_e rw, input db_src_e db, input logic ir);
    return '{rw, db, ir};
  endfunction

  // Enables in the order A X Y S T
  function automatic reg_ctrl_t make_reg(input reg_src_e src, input logic [4:0] we);
    return '{src, we[4], we[3], we[2], we[1], we[0]};
  endfunction

  function automatic alu_ctrl_t make_alu(input alu_op_e op, input alu_src_a_e src,
                                         input p_src_e p, input logic [7:0] mask);
    return '{op, src, p, mask};
  endfunction

  // From the cycle after a fetch edge up to and including the next fetch edge
  task automatic run_instr(input opcode_t opc, output int cycles, output int stalls);
    ctrl_word_t c;
    ctrl_word_t held;
    logic       was_low;
    logic       fetch_edge;
    cycles = 0;
    stalls = 0;
    was_low = 1'b0;
    fetch_edge = 1'b0;
    held = '0;
    wr_log.delete();
    instr = opc;
    while (!fetch_edge) begin
      if (stall_left > 0) begin
        rdy = 1'b0;
        stall_left--;
      end else begin
        rdy = 1'b1;
        if (stall_on) begin
          stall_left = int'(xorshift32() % 4);
        end
      end
      @(negedge CLK);
      c = ctrl;
      cycles++;
      if (was_low) begin
        check_bus("ctrl.bus under stall", held.bus, c.bus);
        check_reg("ctrl.regs under stall", held.regs, c.regs);
        check_alu("ctrl.alu under stall", held.alu, c.alu);
        check_pc("ctrl.pc under stall", held.pc, c.pc);
        check_ab("ctrl.ab under stall", held.ab, c.ab);
      end
      if (!rdy) begin
        stalls++;
      end
      // Only the completing cycle of a stalled write is logged
      if (rdy && c.bus.rw == RW_W) begin
        wr_log.push_back(c);
      end
      fetch_edge = rdy && c.bus.ir_we;
      held = c;
      was_low = !rdy;
      @(posedge CLK);
      #1;
    end
    fetch_word = c;
  endtask

  task automatic reset_word();
    pc_ctrl_t pc_exp;
    ab_ctrl_t ab_exp;
    pc_exp = '{PC_INC, PCL_ADD, PCH_ADD, 1'b1, 1'b1};
    ab_exp = '{ABL_PCN, ABH_PCN, 1'b1, 1'b1};
    @(negedge CLK);
    check_bus("ctrl.bus after reset", make_bus(RW_R, DB_A, 1'b1), ctrl.bus);
    check_reg("ctrl.regs after reset", make_reg(REG_MEM, 5'b00000), ctrl.regs);
    check_pc("ctrl.pc after reset", pc_exp, ctrl.pc);
    check_ab("ctrl.ab after reset", ab_exp, ctrl.ab);
    @(posedge CLK);
    #1;
  endtask

  task automatic instr_lengths();
    int cycles;
    int stalls;
    for (int i = 0; i < 8; i++) begin
      run_instr(len_opc[i], cycles, stalls);
      check_len($sformatf("cycle count of %h", len_opc[i]), len_exp[i], cycles);
    end
  endtask

  task automatic writeback_fields();
    int cycles;
    int stalls;
    run_instr(OPC_LDX_IMM, cycles, stalls);
    check_reg("ctrl.regs after LDX", make_reg(REG_T, 5'b01000), fetch_word.regs);
    run_instr(OPC_TAY, cycles, stalls);
    check_reg("ctrl.regs after TAY", make_reg(REG_A, 5'b00100), fetch_word.regs);
    run_instr(OPC_INX, cycles, stalls);
    check_alu("ctrl.alu after INX", make_alu(ALU_INC, ALUA_X, P_ALU, 8'h00), fetch_word.alu);
    check_reg("ctrl.regs after INX", make_reg(REG_ALU, 5'b01000), fetch_word.regs);
    run_instr(OPC_ADC_IMM, cycles, stalls);
    check_alu("ctrl.alu after ADC", make_alu(ALU_ADC, ALUA_A, P_ALU, 8'h00), fetch_word.alu);
    check_reg("ctrl.regs after ADC", make_reg(REG_ALU, 5'b10000), fetch_word.regs);
    run_instr(OPC_CMP_IMM, cycles, stalls);
    check_alu("ctrl.alu after CMP", make_alu(ALU_CMP, ALUA_A, P_ALU, 8'h00), fetch_word.alu);
    check_reg("ctrl.regs after CMP", make_reg(REG_ALU, 5'b00000), fetch_word.regs);
    run_instr(OPC_SEC, cycles, stalls);
    check_alu("ctrl.alu after SEC", make_alu(ALU_THA, ALUA_A, P_SET, FLAG_MASK_C),
              fetch_word.alu);
  endtask

  task automatic store_write(input opcode_t opc, input db_src_e db);
    int cycles;
    int stalls;
    run_instr(opc, cycles, stalls);
    check_len($sformatf("write count of %h", opc), 1, wr_log.size());
    check_bus($sformatf("write bus of %h", opc), make_bus(RW_W, db, 1'b0), wr_log[0].bus);
  endtask

  task automatic write_cycles();
    int cycles;
    int stalls;
    store_write(OPC_STA_ZPG, DB_A);
    store_write(OPC_STX_ZPG, DB_X);
    store_write(OPC_STY_ZPG, DB_Y);
    run_instr(OPC_INC_ZPG, cycles, stalls);
    check_len("write count of INC", 2, wr_log.size());
    check_bus("second write bus of INC", make_bus(RW_W, DB_T, 1'b0), wr_log[1].bus);
    run_instr(OPC_ASL_ABS, cycles, stalls);
    check_len("write count of ASL", 2, wr_log.size());
    check_bus("second write bus of ASL", make_bus(RW_W, DB_T, 1'b0), wr_log[1].bus);
    // Return address pushed high byte first
    run_instr(OPC_JSR_ABS, cycles, stalls);
    check_len("write count of JSR", 2, wr_log.size());
    check_bus("first push of JSR", make_bus(RW_W, DB_PCH, 1'b0), wr_log[0].bus);
    check_reg("first push regs of JSR", make_reg(REG_ALU, 5'b00010), wr_log[0].regs);
    check_bus("second push of JSR", make_bus(RW_W, DB_PCL, 1'b0), wr_log[1].bus);
    check_reg("second push regs of JSR", make_reg(REG_ALU, 5'b00010), wr_log[1].regs);
  endtask

  task automatic rdy_stalls();
    int cycles;
    int stalls;
    int total;
    int k;
    total = 0;
    stall_on = 1'b1;
    for (int i = 0; i < STALL_INSTR; i++) begin
      k = int'(xorshift32() % 8);
      run_instr(len_opc[k], cycles, stalls);
      check_len($sformatf("stalled cycle count of %h", len_opc[k]), len_exp[k] + stalls, cycles);
      total += stalls;
    end
    stall_on = 1'b0;
    stall_left = 0;
    if (total == 0) begin
      $display("The stall test never held rdy low");
      abort_run();
    end
  endtask

  task automatic unknown_opcode();
    int cycles;
    int stalls;
    run_instr(8'hFF, cycles, stalls);
    check_len("cycle count of unknown opcode", 2, cycles);
    check_len("write count of unknown opcode", 0, wr_log.size());
    check_reg("ctrl.regs after unknown opcode", make_reg(REG_MEM, 5'b00000), fetch_word.regs);
    check_alu("ctrl.alu after unknown opcode", make_alu(ALU_THA, ALUA_A, P_NON, 8'h00),
              fetch_word.alu);
  endtask

  initial begin
    CLK = 1'b0;
    arst_n = 1'b0;
    rdy = 1'b1;
    instr = OPC_NOP;
    rng_state = 32'd29;
    stall_left = 0;
    stall_on = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    arst_n = 1'b1;
    reset_word();
    instr_lengths();
    writeback_fields();
    write_cycles();
    rdy_stalls();
    unknown_opcode();
    $display("Testbench passed");
    $finish;
  end

  initial begin
    #(RUN_LIMIT);
    $display("Watchdog expired after %0d time units", RUN_LIMIT);
    abort_run();
  end

endmodule

/* cpu_controller.f */
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/stack_step_counter.sv
hdl/cycle_sequencer.sv
hdl/control_encoder.sv
hdl/cpu_controller.sv
bench/cpu_controller_tb.sv

/* Makefile */
TOP = cpu_controller_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cpu_controller.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
